// ==== md_config.svh ====
`ifndef MD_CONFIG_SVH
`define MD_CONFIG_SVH

// One sign bit above the magnitude.
`define MD_WORD_BITS 29
`define MD_MAG_BITS (`MD_WORD_BITS - 1)

// Sign stage input FIFO depth.
`define MD_IN_CREDITS 2

// Receiver buffer depth behind the output port.
`define MD_OUT_CREDITS 2

`endif

// ==== md_iter_stage.sv ====
`default_nettype none
`include "md_config.svh"

module md_iter_stage import md_pkg::*; #(
    parameter int unsigned DONE_CREDITS = 2
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     work_valid,
    input  wire md_work_t work,
    output logic          work_credit,
    output logic          done_valid,
    output md_resp_t      done,
    input  wire logic     done_credit
);

    localparam int unsigned CRED_BITS = $clog2(DONE_CREDITS + 1);
    localparam md_step_t LAST_STEP = md_step_t'(`MD_MAG_BITS - 1);

    md_iter_state_t          state;
    md_step_t                step;
    logic [CRED_BITS-1:0]    done_cred;
    logic                    send;
    md_op_t                  op;
    logic                    sign_hi;
    logic                    sign_lo;
    logic                    div_zero;
    md_mag_t                 acc;           // High product or partial remainder.
    md_mag_t                 low;           // Multiplier/low product or dividend/quotient.
    md_mag_t                 oper_b;
    logic [`MD_MAG_BITS:0]   mul_sum;
    logic [`MD_MAG_BITS:0]   div_shift;
    logic [`MD_MAG_BITS+1:0] div_trial;
    logic                    div_fits;

    // The port named done hides the state literal, so it is qualified.
    assign send       = (state == md_pkg::done) && (done_cred != '0);
    assign done_valid = send;

    always_comb begin
        mul_sum   = {1'b0, acc} + (low[0] ? {1'b0, oper_b} : '0);
        div_shift = {acc, low[`MD_MAG_BITS-1]};
        div_trial = {1'b0, div_shift} - {2'b00, oper_b};
        div_fits  = !div_trial[`MD_MAG_BITS+1];    // No borrow.
    end

    always_comb begin
        done.op       = op;
        done.div_zero = div_zero;
        if (op == md_op_div) begin
            done.hi = {sign_hi, low};       // Quotient.
            done.lo = {sign_lo, acc};       // Remainder.
        end else begin
            done.hi = {sign_hi, acc};
            done.lo = {sign_lo, low};
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && work_valid) begin
            op       <= work.op;
            sign_hi  <= work.sign_hi;
            sign_lo  <= work.sign_lo;
            div_zero <= work.div_zero;
            oper_b   <= work.mag_b;
            acc      <= '0;
            low      <= work.div_zero ? '0 : work.mag_a;
        end else if (state == run) begin
            if (op == md_op_mul) begin
                acc <= mul_sum[`MD_MAG_BITS:1];
                low <= {mul_sum[0], low[`MD_MAG_BITS-1:1]};
            end else begin
                acc <= div_fits ? div_trial[`MD_MAG_BITS-1:0] : div_shift[`MD_MAG_BITS-1:0];
                low <= {low[`MD_MAG_BITS-2:0], div_fits};  // Quotient bit in.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= idle;
            step        <= '0;
            done_cred   <= CRED_BITS'(DONE_CREDITS);
            work_credit <= 1'b0;
        end else begin
            work_credit <= send;
            done_cred   <= done_cred - CRED_BITS'(send) + CRED_BITS'(done_credit);
            case (state)
                idle: begin
                    if (work_valid) begin
                        step  <= '0;
                        state <= work.div_zero ? md_pkg::done : run;
                    end
                end
                run: begin
                    step <= step + 1'b1;
                    if (step == LAST_STEP) begin
                        state <= md_pkg::done;
                    end
                end
                md_pkg::done: begin
                    if (send) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== md_pkg.sv ====
`default_nettype none
`include "md_config.svh"

package md_pkg;

    typedef logic [`MD_WORD_BITS-1:0] md_word_t;
    typedef logic [`MD_MAG_BITS-1:0] md_mag_t;
    typedef logic [$clog2(`MD_MAG_BITS + 1)-1:0] md_step_t;    // Reaches MD_MAG_BITS.

    typedef enum logic {
        md_op_mul,
        md_op_div
    } md_op_t;

    typedef struct packed {
        md_op_t   op;
        md_word_t a;
        md_word_t b;
    } md_req_t;

    typedef struct packed {
        md_op_t  op;
        md_mag_t mag_a;
        md_mag_t mag_b;
        logic    sign_hi;       // Product or quotient.
        logic    sign_lo;       // Low product word or remainder.
        logic    div_zero;
    } md_work_t;

    typedef struct packed {
        md_op_t   op;
        md_word_t hi;
        md_word_t lo;
        logic     div_zero;
    } md_resp_t;

    typedef enum logic [1:0] {
        idle,
        run,
        done
    } md_iter_state_t;

endpackage

`default_nettype wire

// ==== md_result_stage.sv ====
`default_nettype none
`include "md_config.svh"

module md_result_stage import md_pkg::*; #(
    parameter int unsigned DEPTH = 2
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     done_valid,
    input  wire md_resp_t done,
    output logic          done_credit,
    output logic          out_valid,
    output md_resp_t      out_resp,
    input  wire logic     out_credit
);

    localparam int unsigned PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CRED_BITS = $clog2(`MD_OUT_CREDITS + 1);

    md_resp_t             res_mem [DEPTH];
    logic [PTR_BITS-1:0]  wr_ptr;
    logic [PTR_BITS-1:0]  rd_ptr;
    logic [PTR_BITS:0]    fill;
    logic [CRED_BITS-1:0] out_cred;
    logic                 send;
    md_resp_t             norm;

    // Zero magnitude always leaves with a positive sign.
    function automatic md_word_t clear_neg_zero(input md_word_t w);
        return (w[`MD_MAG_BITS-1:0] == '0) ? {1'b0, w[`MD_MAG_BITS-1:0]} : w;
    endfunction

    always_comb begin
        norm    = done;
        norm.hi = clear_neg_zero(done.hi);
        norm.lo = clear_neg_zero(done.lo);
    end

    assign send      = (fill != '0) && (out_cred != '0);
    assign out_valid = send;
    assign out_resp  = res_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (done_valid) begin
            res_mem[wr_ptr] <= norm;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            fill        <= '0;
            out_cred    <= CRED_BITS'(`MD_OUT_CREDITS);
            done_credit <= 1'b0;
        end else begin
            if (done_valid) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({done_valid, send})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
            out_cred    <= out_cred - CRED_BITS'(send) + CRED_BITS'(out_credit);
            done_credit <= send;            // Entry left last cycle.
        end
    end

endmodule

`default_nettype wire

// ==== md_sign_stage.sv ====
`default_nettype none
`include "md_config.svh"

module md_sign_stage import md_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    input  wire md_req_t  in_req,
    output logic          in_credit,
    output logic          work_valid,
    output md_work_t      work,
    input  wire logic     work_credit
);

    localparam int unsigned DEPTH = `MD_IN_CREDITS;
    localparam int unsigned PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    md_req_t             fifo_mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   fill;
    logic                work_cred;     // Iteration stage holds one operation.
    logic                pop;
    md_req_t             head;
    logic                sign_a;
    logic                sign_b;

    assign head   = fifo_mem[rd_ptr];
    assign pop    = (fill != '0) && work_cred;
    assign sign_a = head.a[`MD_WORD_BITS-1];
    assign sign_b = head.b[`MD_WORD_BITS-1];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            fifo_mem[wr_ptr] <= in_req;
        end
    end

    // K1/K2 sign logic, resolved once per request.
    always_ff @(posedge clk) begin
        if (pop) begin
            work.op       <= head.op;
            work.mag_a    <= head.a[`MD_MAG_BITS-1:0];
            work.mag_b    <= head.b[`MD_MAG_BITS-1:0];
            work.sign_hi  <= sign_a ^ sign_b;
            work.sign_lo  <= (head.op == md_op_div) ? sign_a : (sign_a ^ sign_b);
            work.div_zero <= (head.op == md_op_div) && (head.b[`MD_MAG_BITS-1:0] == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            work_valid <= 1'b0;
            in_credit  <= 1'b0;
            work_cred  <= 1'b1;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
            work_valid <= pop;
            in_credit  <= pop;              // Slot freed last cycle.
            if (pop && !work_credit) begin
                work_cred <= 1'b0;
            end else if (work_credit && !pop) begin
                work_cred <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== md_unit.sv ====
`default_nettype none

module md_unit import md_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    input  wire md_req_t  in_req,
    output logic          in_credit,
    output logic          out_valid,
    output md_resp_t      out_resp,
    input  wire logic     out_credit
);

    localparam int unsigned DONE_DEPTH = 2;    // Result buffer entries.

    logic     work_valid;
    md_work_t work;
    logic     work_credit;
    logic     done_valid;
    md_resp_t done;
    logic     done_credit;

    md_sign_stage sign0 (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_req      (in_req),
        .in_credit   (in_credit),
        .work_valid  (work_valid),
        .work        (work),
        .work_credit (work_credit)
    );

    md_iter_stage #(
        .DONE_CREDITS (DONE_DEPTH)
    ) iter0 (
        .clk         (clk),
        .rst         (rst),
        .work_valid  (work_valid),
        .work        (work),
        .work_credit (work_credit),
        .done_valid  (done_valid),
        .done        (done),
        .done_credit (done_credit)
    );

    md_result_stage #(
        .DEPTH (DONE_DEPTH)
    ) result0 (
        .clk         (clk),
        .rst         (rst),
        .done_valid  (done_valid),
        .done        (done),
        .done_credit (done_credit),
        .out_valid   (out_valid),
        .out_resp    (out_resp),
        .out_credit  (out_credit)
    );

endmodule

`default_nettype wire

// ==== md_unit_checker.sv ====
`default_nettype none
`include "md_config.svh"

module md_unit_checker import md_pkg::*; (
    input wire logic     clk,
    input wire logic     rst,
    input wire logic     in_valid,
    input wire logic     in_credit,
    input wire logic     out_valid,
    input wire md_resp_t out_resp,
    input wire logic     out_credit
);

    int          in_cnt;        // Credits held by the sender.
    int          out_cnt;       // Credits held by the unit.
    int unsigned fail_count = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_cnt  <= `MD_IN_CREDITS;
            out_cnt <= `MD_OUT_CREDITS;
        end else begin
            in_cnt  <= in_cnt - int'(in_valid) + int'(in_credit);
            out_cnt <= out_cnt - int'(out_valid) + int'(out_credit);
        end
    end

    out_needs_credit: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> (out_cnt > 0))
        else begin
            fail_count++;
            $error("out_valid high with no output credit");
        end

    in_needs_credit: assert property (
        @(posedge clk) disable iff (rst) in_valid |-> (in_cnt > 0))
        else begin
            fail_count++;
            $error("in_valid high with no input credit");
        end

    quiet_after_reset: assert property (
        @(posedge clk) rst |=> (!out_valid && !in_credit))
        else begin
            fail_count++;
            $error("out_valid or in_credit high right after reset");
        end

    resp_known: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> !$isunknown(out_resp))
        else begin
            fail_count++;
            $error("out_resp has unknown bits while out_valid is high");
        end

endmodule

bind md_unit md_unit_checker checker0 (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_resp   (out_resp),
    .out_credit (out_credit)
);

`default_nettype wire

// ==== md_unit_tb.sv ====
`default_nettype none
`include "md_config.svh"

module md_unit_tb import md_pkg::*; ();

    localparam int N_DIRECTED = 13;
    localparam int N_RANDOM   = 16;
    localparam int N_SLOW     = 16;
    localparam int N_BURST    = 10;
    localparam int TOTAL_REQS = N_DIRECTED + N_RANDOM + N_SLOW + N_BURST;
    localparam md_mag_t FULL  = '1;

    logic        clk;
    logic        rst;
    logic        in_valid;
    md_req_t     in_req;
    logic        in_credit;
    logic        out_valid;
    md_resp_t    out_resp;
    logic        out_credit;
    logic [31:0] lfsr = 32'h1ea0;
    logic        slow_credits = 1'b0;
    md_resp_t    expected[$];
    int          in_cred = `MD_IN_CREDITS;
    int          credit_pulses = 0;
    int          sent = 0;
    int          consumed = 0;     // Results taken by the receiver.
    int          returned = 0;

    md_unit dut0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_resp   (out_resp),
        .out_credit (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic md_word_t signed_word(input logic s, input md_mag_t m);
        return {s && (m != '0), m};
    endfunction

    function automatic md_resp_t expect_resp(input md_req_t r);
        md_resp_t                  res;
        md_mag_t                   ma;
        md_mag_t                   mb;
        logic [2*`MD_MAG_BITS-1:0] wa;
        logic [2*`MD_MAG_BITS-1:0] wb;
        logic [2*`MD_MAG_BITS-1:0] prod;
        ma = r.a[`MD_MAG_BITS-1:0];
        mb = r.b[`MD_MAG_BITS-1:0];
        wa = ma;
        wb = mb;
        prod = wa * wb;
        res.op = r.op;
        res.div_zero = 1'b0;
        if (r.op == md_op_mul) begin
            res.hi = signed_word(r.a[`MD_MAG_BITS] ^ r.b[`MD_MAG_BITS],
                                 prod[2*`MD_MAG_BITS-1:`MD_MAG_BITS]);
            res.lo = signed_word(r.a[`MD_MAG_BITS] ^ r.b[`MD_MAG_BITS],
                                 prod[`MD_MAG_BITS-1:0]);
        end else if (mb == '0) begin
            res.div_zero = 1'b1;
            res.hi = '0;
            res.lo = '0;
        end else begin
            res.hi = signed_word(r.a[`MD_MAG_BITS] ^ r.b[`MD_MAG_BITS], ma / mb);
            res.lo = signed_word(r.a[`MD_MAG_BITS], ma % mb);   // Dividend sign.
        end
        return res;
    endfunction

    function automatic md_req_t make_req(input md_op_t op, input logic sa, input md_mag_t ma,
                                         input logic sb, input md_mag_t mb);
        md_req_t r;
        r.op = op;
        r.a = {sa, ma};
        r.b = {sb, mb};
        return r;
    endfunction

    function automatic md_req_t random_req();
        md_req_t    r;
        logic [2:0] pick;
        r.op = md_op_t'(take_bits(1) != 0);
        r.a = md_word_t'(take_bits(`MD_WORD_BITS));
        r.b = md_word_t'(take_bits(`MD_WORD_BITS));
        pick = 3'(take_bits(3));
        case (pick)
            3'd0: r.a[`MD_MAG_BITS-1:0] = '0;
            3'd1: r.b[`MD_MAG_BITS-1:0] = '0;
            3'd2: r.a[`MD_MAG_BITS-1:0] = FULL;
            3'd3: r.b[`MD_MAG_BITS-1:0] = FULL;
            default: ;
        endcase
        return r;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_req(input md_req_t r);
        while (in_cred == 0) idle_cycles(1);
        in_valid = 1'b1;
        in_req = r;
        expected.push_back(expect_resp(r));
        sent++;
        idle_cycles(1);
        in_valid = 1'b0;
    endtask

    task automatic value_error(input string what, input logic [63:0] want,
                               input logic [63:0] got);
        $display("ERROR %0t: %s expected %h, got %h", $time, what, want, got);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_result();
        md_resp_t want;
        assert (expected.size() != 0) else abort_run("Result arrived with no request pending");
        assert (consumed - returned < `MD_OUT_CREDITS)
            else abort_run("Receiver buffer overflowed");
        want = expected.pop_front();
        consumed++;
        assert (out_resp.op == want.op) else value_error("op", 64'(want.op), 64'(out_resp.op));
        assert (out_resp.div_zero == want.div_zero)
            else value_error("div_zero", 64'(want.div_zero), 64'(out_resp.div_zero));
        assert (out_resp.hi == want.hi) else value_error("hi", 64'(want.hi), 64'(out_resp.hi));
        assert (out_resp.lo == want.lo) else value_error("lo", 64'(want.lo), 64'(out_resp.lo));
    endtask

    always @(negedge clk) begin
        if (rst) begin
            in_cred = `MD_IN_CREDITS;
        end else begin
            in_cred = in_cred - int'(in_valid) + int'(in_credit);
            credit_pulses += int'(in_credit);
            if (out_valid) check_result();
        end
    end

    always @(negedge clk) begin
        if (dut0.checker0.fail_count != 0) begin
            abort_run("A port protocol assertion in md_unit_checker failed");
        end
    end

    // Receiver frees one buffered result after a random delay.
    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            out_credit = 1'b0;
            if (consumed > returned && take_bits(slow_credits ? 4 : 1) == 0) begin
                out_credit = 1'b1;
                returned++;
            end
        end
    end

    initial begin
        #(40 * (TOTAL_REQS * (`MD_MAG_BITS + 10) + 500));
        $display("Timeout: results stopped arriving, %0d still pending", expected.size());
        $display("Verification failed");
        $fatal(1);
    end

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        in_req = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        send_req(make_req(md_op_mul, 1'b0, 3, 1'b0, 5));
        send_req(make_req(md_op_mul, 1'b1, FULL, 1'b0, FULL));
        send_req(make_req(md_op_mul, 1'b1, 7, 1'b1, 9));
        send_req(make_req(md_op_mul, 1'b1, 5, 1'b0, 0));        // Zero product.
        send_req(make_req(md_op_div, 1'b0, 100, 1'b0, 7));
        send_req(make_req(md_op_div, 1'b1, 100, 1'b0, 7));
        send_req(make_req(md_op_div, 1'b0, 100, 1'b1, 7));
        send_req(make_req(md_op_div, 1'b1, 12, 1'b0, 3));       // Zero remainder.
        send_req(make_req(md_op_div, 1'b0, FULL, 1'b0, 1));
        send_req(make_req(md_op_div, 1'b1, 0, 1'b1, 5));
        send_req(make_req(md_op_div, 1'b0, 5, 1'b0, 0));
        send_req(make_req(md_op_div, 1'b1, FULL, 1'b1, 0));
        send_req(make_req(md_op_div, 1'b0, 3, 1'b0, FULL));
        repeat (N_RANDOM) begin
            send_req(random_req());
            idle_cycles(int'(take_bits(2)));
        end
        slow_credits = 1'b1;
        repeat (N_SLOW) send_req(random_req());
        while (expected.size() != 0) idle_cycles(1);
        slow_credits = 1'b0;
        repeat (N_BURST) send_req(random_req());   // Back to back.
        while (expected.size() != 0) idle_cycles(1);
        idle_cycles(4);
        if (credit_pulses == sent && in_cred == `MD_IN_CREDITS) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("ERROR %0t: %0d in_credit pulses for %0d requests", $time,
                     credit_pulses, sent);
            $display("Verification failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the multiply/divide unit testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module md_unit_tb -f verilog.f

# The run may stop on failure, so its status is taken from the output.
output=$(./obj_dir/Vmd_unit_tb +verilator+error+limit+100 2>&1) || true
echo "$output"

if grep -qx "Verification passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== verilog.f ====
+incdir+.
md_pkg.sv
md_sign_stage.sv
md_iter_stage.sv
md_result_stage.sv
md_unit.sv
md_unit_checker.sv
md_unit_tb.sv
